/* axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model
    import cache_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset_in,

    input  addr_t       awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  word_t       wdata,
    input  byte_mask_t  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    input  addr_t       araddr,
    input  logic        arvalid,
    output logic        arready,
    output word_t       rdata,
    output logic        rvalid,
    input  logic        rready,

    output int          ar_count,
    output int          aw_count
);

localparam int MEM_WORDS = 1024;

word_t      mem [MEM_WORDS];
integer     seed = 32'h954;
logic [1:0] aw_wait;
logic [1:0] w_wait;
logic [1:0] ar_wait;
logic       aw_got;
logic       w_got;
addr_t      aw_addr_q;
word_t      w_data_q;
byte_mask_t w_strb_q;

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] <= word_t'(i) ^ 32'hA5A5_0000;
        end
        {awready, wready, bvalid, arready, rvalid} <= '0;
        {aw_got, w_got} <= '0;
        {aw_wait, w_wait, ar_wait} <= '0;
        ar_count <= 0;
        aw_count <= 0;
    end
    else
    begin
        // each ready comes 0 to 3 cycles after its valid
        if (awvalid && awready)
        begin
            awready   <= 1'b0;
            aw_got    <= 1'b1;
            aw_addr_q <= awaddr;
            aw_count  <= aw_count + 1;
            aw_wait   <= 2'($random(seed));
        end
        else if (awvalid && !aw_got)
        begin
            if (aw_wait == 2'd0)
            begin
                awready <= 1'b1;
            end
            else
            begin
                aw_wait <= aw_wait - 2'd1;
            end
        end

        if (wvalid && wready)
        begin
            wready   <= 1'b0;
            w_got    <= 1'b1;
            w_data_q <= wdata;
            w_strb_q <= wstrb;
            w_wait   <= 2'($random(seed));
        end
        else if (wvalid && !w_got)
        begin
            if (w_wait == 2'd0)
            begin
                wready <= 1'b1;
            end
            else
            begin
                w_wait <= w_wait - 2'd1;
            end
        end

        // write lands once both address and data are in
        if (aw_got && w_got && !bvalid)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (w_strb_q[i])
                begin
                    mem[aw_addr_q[11:2]][8 * i +: 8] <= w_data_q[8 * i +: 8];
                end
            end
            bvalid <= 1'b1;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end
        if (bvalid && bready)
        begin
            bvalid <= 1'b0;
        end

        if (arvalid && arready)
        begin
            arready  <= 1'b0;
            rvalid   <= 1'b1;
            rdata    <= mem[araddr[11:2]];
            ar_count <= ar_count + 1;
            ar_wait  <= 2'($random(seed));
        end
        else if (arvalid && !rvalid)
        begin
            if (ar_wait == 2'd0)
            begin
                arready <= 1'b1;
            end
            else
            begin
                ar_wait <= ar_wait - 2'd1;
            end
        end
        if (rvalid && rready)
        begin
            rvalid <= 1'b0;
        end
    end
end

endmodule

/* axi_single_master.sv */
`timescale 1ns/10ps
`include "cache_consts.svh"

module axi_single_master
    import cache_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset_in,

    input  logic        start,
    input  logic        write,
    input  addr_t       addr,
    input  word_t       wdata,
    input  byte_mask_t  wstrb,
    output logic        done,
    output word_t       rdata,

    output addr_t       awaddr,
    output logic        awvalid,
    input  logic        awready,
    output word_t       wdata_axi,
    output byte_mask_t  wstrb_axi,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready,
    output addr_t       araddr,
    output logic        arvalid,
    input  logic        arready,
    input  word_t       rdata_axi,
    input  logic        rvalid,
    output logic        rready
);

typedef enum logic [2:0]
{
    AXI_IDLE,
    AXI_WRITE,
    AXI_WRESP,
    AXI_READ,
    AXI_RDATA
} axi_state_t;

axi_state_t state;
addr_t      axi_addr;
logic       aw_clear;
logic       w_clear;

assign awaddr = axi_addr;
assign araddr = axi_addr;

// channel finished already or handshaking this cycle
assign aw_clear = ~awvalid | awready;
assign w_clear  = ~wvalid | wready;

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        state   <= AXI_IDLE;
        done    <= 1'b0;
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
    end
    else
    begin
        done <= 1'b0;

        case (state)
            AXI_IDLE:
            begin
                if (start && write)
                begin
                    awvalid <= 1'b1;
                    wvalid  <= 1'b1;
                    state   <= AXI_WRITE;
                end
                else if (start)
                begin
                    arvalid <= 1'b1;
                    state   <= AXI_READ;
                end
            end

            // AW and W complete in either order
            AXI_WRITE:
            begin
                if (awready)
                begin
                    awvalid <= 1'b0;
                end
                if (wready)
                begin
                    wvalid <= 1'b0;
                end
                if (aw_clear && w_clear)
                begin
                    bready <= 1'b1;
                    state  <= AXI_WRESP;
                end
            end

            AXI_WRESP:
            begin
                if (bvalid)
                begin
                    bready <= 1'b0;
                    done   <= 1'b1;
                    state  <= AXI_IDLE;
                end
            end

            AXI_READ:
            begin
                if (arready)
                begin
                    arvalid <= 1'b0;
                    rready  <= 1'b1;
                    state   <= AXI_RDATA;
                end
            end

            AXI_RDATA:
            begin
                if (rvalid)
                begin
                    rready <= 1'b0;
                    done   <= 1'b1;
                    state  <= AXI_IDLE;
                end
            end

            default:
            begin
                state <= AXI_IDLE;
            end
        endcase
    end
end

always_ff @(posedge clk_in)
begin
    if (state == AXI_IDLE && start)
    begin
        axi_addr  <= {addr[`CACHE_ADDR_WIDTH - 1 : `CACHE_OFFSET_WIDTH],
                      {`CACHE_OFFSET_WIDTH{1'b0}}} + `CACHE_AXI_BASE_ADDR;
        wdata_axi <= wdata;
        wstrb_axi <= wstrb;
    end

    if (state == AXI_RDATA && rvalid)
    begin
        rdata <= rdata_axi;
    end
end

awvalid_held: assert property (@(posedge clk_in) disable iff (reset_in)
    awvalid && !awready |=> awvalid);

wvalid_held: assert property (@(posedge clk_in) disable iff (reset_in)
    wvalid && !wready |=> wvalid);

arvalid_held: assert property (@(posedge clk_in) disable iff (reset_in)
    arvalid && !arready |=> arvalid);

endmodule

/* cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// cache geometry, one word per block
`define CACHE_NUM_SET           16
`define CACHE_INDEX_WIDTH       $clog2(`CACHE_NUM_SET)
`define CACHE_OFFSET_WIDTH      2

// datapath widths
`define CACHE_ADDR_WIDTH        32
`define CACHE_DATA_WIDTH        32
`define CACHE_BYTES_PER_WORD    (`CACHE_DATA_WIDTH / 8)

// memory window seen on the AXI side
`define CACHE_AXI_BASE_ADDR     32'h0000_0000

`endif

/* cache_core.sv */
`timescale 1ns/10ps
`include "cache_consts.svh"

module cache_core
    import cache_pkg::*;
(
    input  logic            clk_in,
    input  logic            reset_in,

    input  cache_packet_t   request_packet,
    input  logic            request_req,
    output logic            request_ack,

    output cache_packet_t   return_packet,
    output logic            return_req,
    input  logic            return_ack,

    output cache_packet_t   mem_packet,
    output logic            mem_req,
    input  logic            mem_ack,
    input  word_t           mem_rdata
);

typedef enum logic [2:0]
{
    CORE_IDLE,
    CORE_ACCEPT,
    CORE_LOOKUP,
    CORE_MEMORY,
    CORE_FILL,
    CORE_RETURN
} core_state_t;

core_state_t                        state;
cache_packet_t                      req_q;

logic [`CACHE_NUM_SET - 1 : 0]      valid_array;
tag_t                               tag_array  [`CACHE_NUM_SET];
word_t                              data_array [`CACHE_NUM_SET];

set_index_t                         req_index;
tag_t                               req_tag;
logic                               hit_q;
word_t                              line_q;
word_t                              rdata_q;
word_t                              merged_line;

logic                               hit_return;
logic                               fill_done;
logic                               fill_en;
logic                               ret_load;
cache_packet_t                      ret_next;

assign req_index  = req_q.addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
assign req_tag    = req_q.addr[`CACHE_ADDR_WIDTH - 1 : `CACHE_OFFSET_WIDTH + `CACHE_INDEX_WIDTH];
assign mem_packet = req_q;

// only a cacheable read that hits skips memory
assign hit_return = (state == CORE_LOOKUP) & ~request_req &
                    req_q.cacheable & ~req_q.is_write & hit_q;

// memory side finished once the bridge has dropped its ack
assign fill_done  = (state == CORE_FILL) & ~mem_ack;
assign fill_en    = fill_done & req_q.cacheable & (~req_q.is_write | hit_q);
assign ret_load   = hit_return | fill_done;

// write hit merges the selected bytes into the old line
always_comb
begin
    merged_line = line_q;
    for (int i = 0; i < $bits(byte_mask_t); i++)
    begin
        if (req_q.byte_mask[i])
        begin
            merged_line[8 * i +: 8] = req_q.data[8 * i +: 8];
        end
    end
end

always_comb
begin
    ret_next = req_q;
    if (hit_return)
    begin
        ret_next.data = line_q;
    end
    else if (!req_q.is_write)
    begin
        ret_next.data = rdata_q;
    end
end

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        state       <= CORE_IDLE;
        request_ack <= 1'b0;
        return_req  <= 1'b0;
        mem_req     <= 1'b0;
        valid_array <= '0;
    end
    else
    begin
        case (state)
            CORE_IDLE:
            begin
                if (request_req)
                begin
                    request_ack <= 1'b1;
                    state       <= CORE_ACCEPT;
                end
            end

            CORE_ACCEPT:
            begin
                state <= CORE_LOOKUP;
            end

            CORE_LOOKUP:
            begin
                if (!request_req)
                begin
                    request_ack <= 1'b0;
                    if (hit_return)
                    begin
                        return_req <= 1'b1;
                        state      <= CORE_RETURN;
                    end
                    else
                    begin
                        mem_req <= 1'b1;
                        state   <= CORE_MEMORY;
                    end
                end
            end

            CORE_MEMORY:
            begin
                if (mem_ack)
                begin
                    mem_req <= 1'b0;
                    state   <= CORE_FILL;
                end
            end

            CORE_FILL:
            begin
                if (!mem_ack)
                begin
                    if (fill_en)
                    begin
                        valid_array[req_index] <= 1'b1;
                    end
                    return_req <= 1'b1;
                    state      <= CORE_RETURN;
                end
            end

            CORE_RETURN:
            begin
                if (return_req)
                begin
                    if (return_ack)
                    begin
                        return_req <= 1'b0;
                    end
                end
                else if (!return_ack)
                begin
                    state <= CORE_IDLE;
                end
            end

            default:
            begin
                state <= CORE_IDLE;
            end
        endcase
    end
end

always_ff @(posedge clk_in)
begin
    if (state == CORE_IDLE && request_req)
    begin
        req_q <= request_packet;
    end

    // arrays only change in fill, so one lookup per request is enough
    if (state == CORE_ACCEPT)
    begin
        hit_q  <= valid_array[req_index] && (tag_array[req_index] == req_tag);
        line_q <= data_array[req_index];
    end

    if (state == CORE_MEMORY && mem_ack)
    begin
        rdata_q <= mem_rdata;
    end

    if (fill_en)
    begin
        tag_array[req_index]  <= req_tag;
        data_array[req_index] <= req_q.is_write ? merged_line : rdata_q;
    end

    if (ret_load)
    begin
        return_packet <= ret_next;
    end
end

return_packet_stable: assert property (@(posedge clk_in) disable iff (reset_in)
    return_req && !return_ack |=> $stable(return_packet));

no_accept_during_return: assert property (@(posedge clk_in) disable iff (reset_in)
    $rose(request_ack) |-> !return_req);

endmodule

/* cache_pkg.sv */
`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_WIDTH - 1 : 0]       addr_t;
    typedef logic [`CACHE_DATA_WIDTH - 1 : 0]       word_t;
    typedef logic [`CACHE_BYTES_PER_WORD - 1 : 0]   byte_mask_t;
    typedef logic [`CACHE_INDEX_WIDTH - 1 : 0]      set_index_t;

    // upper address bits above index and byte offset
    typedef logic [`CACHE_ADDR_WIDTH - `CACHE_INDEX_WIDTH - `CACHE_OFFSET_WIDTH - 1 : 0] tag_t;

    // request and return packet, 70 bits
    typedef struct packed
    {
        logic       cacheable;
        logic       is_write;
        byte_mask_t byte_mask;
        word_t      data;
        addr_t      addr;
    } cache_packet_t;

endpackage

/* mem_bridge.sv */
`timescale 1ns/10ps

module mem_bridge
    import cache_pkg::*;
(
    input  logic            clk_in,
    input  logic            reset_in,

    // four-phase side toward the core
    input  cache_packet_t   mem_packet,
    input  logic            mem_req,
    output logic            mem_ack,
    output word_t           mem_rdata,

    // pulse side toward the AXI master
    output logic            start,
    output logic            write,
    output addr_t           addr,
    output word_t           wdata,
    output byte_mask_t      wstrb,
    input  logic            done,
    input  word_t           rdata
);

logic   busy;
logic   launch;

// new request not yet handed to the master
assign launch = mem_req & ~busy & ~mem_ack;

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        start   <= 1'b0;
        busy    <= 1'b0;
        mem_ack <= 1'b0;
    end
    else
    begin
        start <= launch;

        if (launch)
        begin
            busy <= 1'b1;
        end

        if (done)
        begin
            busy    <= 1'b0;
            mem_ack <= 1'b1;
        end
        else if (mem_ack && !mem_req)
        begin
            mem_ack <= 1'b0;
        end
    end
end

always_ff @(posedge clk_in)
begin
    if (launch)
    begin
        write <= mem_packet.is_write;
        addr  <= mem_packet.addr;
        wdata <= mem_packet.data;
        wstrb <= mem_packet.byte_mask;
    end

    // held for the core while ack is up
    if (done)
    begin
        mem_rdata <= rdata;
    end
end

start_only_without_ack: assert property (@(posedge clk_in) disable iff (reset_in)
    start |-> !mem_ack);

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module unified_cache_tb -f sim.f

output=$(./obj_dir/Vunified_cache_tb || true)
echo "$output"

if echo "$output" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1

/* sim.f */
+incdir+.
cache_pkg.sv
cache_core.sv
mem_bridge.sv
axi_single_master.sv
unified_cache_axi_top.sv
axi_mem_model.sv
unified_cache_tb.sv

/* unified_cache_axi_top.sv */
`timescale 1ns/10ps

module unified_cache_axi_top
    import cache_pkg::*;
(
    input  logic            clk_in,
    input  logic            reset_in,

    input  cache_packet_t   request_packet,
    input  logic            request_req,
    output logic            request_ack,

    output cache_packet_t   return_packet,
    output logic            return_req,
    input  logic            return_ack,

    output addr_t           awaddr,
    output logic            awvalid,
    input  logic            awready,
    output word_t           wdata,
    output byte_mask_t      wstrb,
    output logic            wvalid,
    input  logic            wready,
    input  logic            bvalid,
    output logic            bready,
    output addr_t           araddr,
    output logic            arvalid,
    input  logic            arready,
    input  word_t           rdata,
    input  logic            rvalid,
    output logic            rready
);

cache_packet_t  mem_packet;
logic           mem_req;
logic           mem_ack;
word_t          mem_rdata;

// single transaction handoff between bridge and master
logic           txn_start;
logic           txn_write;
addr_t          txn_addr;
word_t          txn_wdata;
byte_mask_t     txn_wstrb;
logic           txn_done;
word_t          txn_rdata;

cache_core cache_core_inst
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .request_packet (request_packet),
    .request_req    (request_req),
    .request_ack    (request_ack),
    .return_packet  (return_packet),
    .return_req     (return_req),
    .return_ack     (return_ack),
    .mem_packet     (mem_packet),
    .mem_req        (mem_req),
    .mem_ack        (mem_ack),
    .mem_rdata      (mem_rdata)
);

mem_bridge mem_bridge_inst
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .mem_packet     (mem_packet),
    .mem_req        (mem_req),
    .mem_ack        (mem_ack),
    .mem_rdata      (mem_rdata),
    .start          (txn_start),
    .write          (txn_write),
    .addr           (txn_addr),
    .wdata          (txn_wdata),
    .wstrb          (txn_wstrb),
    .done           (txn_done),
    .rdata          (txn_rdata)
);

axi_single_master axi_single_master_inst
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .start          (txn_start),
    .write          (txn_write),
    .addr           (txn_addr),
    .wdata          (txn_wdata),
    .wstrb          (txn_wstrb),
    .done           (txn_done),
    .rdata          (txn_rdata),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata_axi      (wdata),
    .wstrb_axi      (wstrb),
    .wvalid         (wvalid),
    .wready         (wready),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata_axi      (rdata),
    .rvalid         (rvalid),
    .rready         (rready)
);

endmodule

/* unified_cache_tb.sv */
`timescale 1ns/10ps

module unified_cache_tb
    import cache_pkg::*;
();

localparam int    NUM_TESTS       = 6;
localparam int    RESET_CYCLES    = 16;
localparam int    CYCLES_PER_TEST = 200;
localparam int    MEM_WORDS       = 1024;

// A0 in set 1, A1 in set 2, B0 and B1 both in set 3
localparam addr_t ADDR_A0 = 32'h0000_0104;
localparam addr_t ADDR_A1 = 32'h0000_0208;
localparam addr_t ADDR_B0 = 32'h0000_030C;
localparam addr_t ADDR_B1 = 32'h0000_044C;

logic           clk_in = 1'b0;
logic           reset_in;
cache_packet_t  request_packet;
cache_packet_t  return_packet;
logic           request_req;
logic           request_ack;
logic           return_req;
logic           return_ack;

addr_t          awaddr;
addr_t          araddr;
word_t          wdata;
word_t          rdata;
byte_mask_t     wstrb;
logic           awvalid;
logic           awready;
logic           wvalid;
logic           wready;
logic           bvalid;
logic           bready;
logic           arvalid;
logic           arready;
logic           rvalid;
logic           rready;
int             ar_count;
int             aw_count;

word_t          ref_mem [MEM_WORDS];
word_t          exp_data;
cache_packet_t  exp_request;
int             exp_ar;
int             exp_aw;
logic           count_check;
int             error_count;
int             errors_before;
int             failed_tests;
int             test_num;
integer         seed = 32'h954;

always #2 clk_in = ~clk_in;

unified_cache_axi_top unified_cache_axi_top_inst
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .request_packet (request_packet),
    .request_req    (request_req),
    .request_ack    (request_ack),
    .return_packet  (return_packet),
    .return_req     (return_req),
    .return_ack     (return_ack),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wstrb          (wstrb),
    .wvalid         (wvalid),
    .wready         (wready),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rvalid         (rvalid),
    .rready         (rready)
);

axi_mem_model axi_mem_model_inst
(
    .clk_in   (clk_in),
    .reset_in (reset_in),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rvalid   (rvalid),
    .rready   (rready),
    .ar_count (ar_count),
    .aw_count (aw_count)
);

reset_quiet_check: assert property (@(posedge clk_in)
    $fell(reset_in) |-> !request_ack && !return_req && !awvalid && !wvalid && !arvalid)
else
begin
    error_count++;
    $display("a handshake or AXI valid was high right after reset");
end

return_data_check: assert property (@(posedge clk_in) disable iff (reset_in)
    $rose(return_req) |-> return_packet.data == exp_data)
else
begin
    error_count++;
    $display("** Error: return_packet.data = %h, expected %h", return_packet.data, exp_data);
end

// every field other than data comes back as it was sent
return_fields_check: assert property (@(posedge clk_in) disable iff (reset_in)
    $rose(return_req) |-> return_packet.addr == exp_request.addr &&
        return_packet.cacheable == exp_request.cacheable &&
        return_packet.is_write == exp_request.is_write &&
        return_packet.byte_mask == exp_request.byte_mask)
else
begin
    error_count++;
    $display("** Error: return_packet = %h, request fields %h", return_packet, exp_request);
end

return_hold_check: assert property (@(posedge clk_in) disable iff (reset_in)
    return_req && !return_ack |=> $stable(return_packet))
else
begin
    error_count++;
    $display("** Error: return_packet = %h changed before return_ack", return_packet);
end

no_accept_check: assert property (@(posedge clk_in) disable iff (reset_in)
    request_ack |-> !return_req && !return_ack)
else
begin
    error_count++;
    $display("request_ack came before the return handshake finished");
end

ar_count_check: assert property (@(posedge clk_in) count_check |-> ar_count == exp_ar)
else
begin
    error_count++;
    $display("** Error: ar_count = %h, expected %h", ar_count, exp_ar);
end

aw_count_check: assert property (@(posedge clk_in) count_check |-> aw_count == exp_aw)
else
begin
    error_count++;
    $display("** Error: aw_count = %h, expected %h", aw_count, exp_aw);
end

function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                      input byte_mask_t mask);
    word_t result;
    result = old_word;
    for (int i = 0; i < 4; i++)
    begin
        if (mask[i])
        begin
            result[8 * i +: 8] = new_word[8 * i +: 8];
        end
    end
    return result;
endfunction

function automatic cache_packet_t make_packet(input logic cacheable, input logic is_write,
                                              input byte_mask_t mask, input word_t data,
                                              input addr_t addr);
    cache_packet_t pkt;
    pkt.cacheable = cacheable;
    pkt.is_write  = is_write;
    pkt.byte_mask = mask;
    pkt.data      = data;
    pkt.addr      = addr;
    return pkt;
endfunction

task automatic raise_request(input cache_packet_t pkt, input word_t expect_word);
    @(posedge clk_in);
    request_packet <= pkt;
    request_req    <= 1'b1;
    exp_data       <= expect_word;
    exp_request    <= pkt;
endtask

task automatic finish_request();
    @(posedge clk_in);
    while (!request_ack) @(posedge clk_in);
    request_req <= 1'b0;
    @(posedge clk_in);
    while (request_ack) @(posedge clk_in);
endtask

task automatic collect_return(input int hold_cycles);
    while (!return_req) @(posedge clk_in);
    repeat (hold_cycles) @(posedge clk_in);
    return_ack <= 1'b1;
    @(posedge clk_in);
    while (return_req) @(posedge clk_in);
    return_ack <= 1'b0;
endtask

task automatic check_counts(input int ar_inc, input int aw_inc);
    @(posedge clk_in);
    exp_ar      <= exp_ar + ar_inc;
    exp_aw      <= exp_aw + aw_inc;
    count_check <= 1'b1;
    @(posedge clk_in);
    count_check <= 1'b0;
endtask

task automatic run_access(input logic cacheable, input logic is_write, input byte_mask_t mask,
                          input word_t data, input addr_t addr, input int ar_inc,
                          input int aw_inc);
    word_t expect_word;
    if (is_write)
    begin
        // write returns its own data, memory takes the strobed bytes
        expect_word = data;
        ref_mem[addr[11:2]] = merge_bytes(ref_mem[addr[11:2]], data, mask);
    end
    else
    begin
        expect_word = ref_mem[addr[11:2]];
    end
    raise_request(make_packet(cacheable, is_write, mask, data, addr), expect_word);
    finish_request();
    collect_return(0);
    check_counts(ar_inc, aw_inc);
endtask

task automatic finish_test(input string name);
    repeat (2) @(posedge clk_in);
    test_num++;
    if (error_count == errors_before)
    begin
        $display("test %0d %s: passed", test_num, name);
    end
    else
    begin
        failed_tests++;
        $display("test %0d %s: failed", test_num, name);
    end
    errors_before = error_count;
endtask

initial
begin
    repeat (RESET_CYCLES + CYCLES_PER_TEST * NUM_TESTS) @(posedge clk_in);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
end

initial
begin
    int hold_cycles;
    reset_in       = 1'b1;
    request_packet = '0;
    request_req    = 1'b0;
    return_ack     = 1'b0;
    exp_data       = '0;
    exp_request    = '0;
    exp_ar         = 0;
    exp_aw         = 0;
    count_check    = 1'b0;
    error_count    = 0;
    errors_before  = 0;
    failed_tests   = 0;
    test_num       = 0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
        ref_mem[i] = word_t'(i) ^ 32'hA5A5_0000;
    end

    repeat (RESET_CYCLES) @(posedge clk_in);
    reset_in <= 1'b0;
    repeat (3) @(posedge clk_in);
    finish_test("reset state");

    run_access(1'b1, 1'b0, 4'hF, '0, ADDR_A0, 1, 0);
    run_access(1'b1, 1'b0, 4'hF, '0, ADDR_A0, 0, 0);
    finish_test("read miss then hit");

    run_access(1'b1, 1'b1, 4'b0101, 32'h1122_3344, ADDR_A0, 0, 1);
    run_access(1'b1, 1'b0, 4'hF, '0, ADDR_A0, 0, 0);
    // memory copy must carry the same merged word
    run_access(1'b0, 1'b0, 4'hF, '0, ADDR_A0, 1, 0);
    finish_test("write hit merge");

    run_access(1'b0, 1'b0, 4'hF, '0, ADDR_A1, 1, 0);
    run_access(1'b0, 1'b0, 4'hF, '0, ADDR_A1, 1, 0);
    run_access(1'b1, 1'b0, 4'hF, '0, ADDR_A1, 1, 0);
    finish_test("uncacheable read");

    for (int i = 0; i < 4; i++)
    begin
        run_access(1'b1, 1'b0, 4'hF, '0, (i % 2 == 0) ? ADDR_B0 : ADDR_B1, 1, 0);
    end
    finish_test("set conflict");

    // next request waits while the return is held off
    hold_cycles = 3 + ({$random(seed)} % 8);
    raise_request(make_packet(1'b1, 1'b0, 4'hF, '0, ADDR_A0), ref_mem[ADDR_A0[11:2]]);
    finish_request();
    while (!return_req) @(posedge clk_in);
    raise_request(make_packet(1'b1, 1'b0, 4'hF, '0, ADDR_A1), ref_mem[ADDR_A1[11:2]]);
    collect_return(hold_cycles);
    check_counts(0, 0);
    finish_request();
    collect_return(0);
    check_counts(0, 0);
    finish_test("return back-pressure");

    repeat (2) @(posedge clk_in);
    $display("tests run %0d, tests failed %0d, assertion errors %0d",
             test_num, failed_tests, error_count);
    if (error_count == 0)
    begin
        $display("TEST OK");
    end
    else
    begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule
